// File: all.f
+incdir+source
source/bpu_types_pkg.sv
source/ftq_types_pkg.sv
source/bpu_ftq_if.sv
source/bpu.sv
source/ftq.sv
source/frontend_top.sv
dv/frontend_props.sv
dv/frontend_tb.sv

// File: dv/frontend_props.sv
`include "frontend_config.svh"
`default_nettype none

module frontend_props #(
    parameter int PTR_W = 3
) (
    input wire             clk,
    input wire             rst,
    input wire [PTR_W-1:0] bpu_ptr_i,
    input wire [PTR_W-1:0] ifu_ptr_i,
    input wire [PTR_W-1:0] comm_ptr_i,
    input wire             queue_full_i,
    input wire             flush_i,
    input wire             ifu_valid_i,
    input wire             redirect_i,
    input wire             train_valid_i,
    input wire             commit_lane0_i,
    input wire             commit_branch_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // Queue state is clean in the first cycle out of reset
    assert property (@(posedge clk) $fell(rst) |->
        !ifu_valid_i && !redirect_i && !queue_full_i && !train_valid_i)
        else $error("outputs active in the cycle after reset");

    // Distance from the commit pointer orders the three pointers
    assert property (@(posedge clk) disable iff (rst)
        PTR_W'(ifu_ptr_i - comm_ptr_i) <= PTR_W'(bpu_ptr_i - comm_ptr_i))
        else $error("ifu_ptr passed bpu_ptr");

    // A full queue takes no new block unless flushed
    assert property (@(posedge clk) disable iff (rst)
        queue_full_i && !flush_i |=> $stable(bpu_ptr_i))
        else $error("P0 write while the queue is full");

    assert property (@(posedge clk) disable iff (rst)
        train_valid_i |-> $past(commit_lane0_i && commit_branch_i))
        else $error("training record without a branch commit");

endmodule

bind ftq frontend_props #(.PTR_W($clog2(`FTQ_SIZE))) props0 (
    .clk             (clk),
    .rst             (rst),
    .bpu_ptr_i       (bpu_ptr),
    .ifu_ptr_i       (ifu_ptr),
    .comm_ptr_i      (comm_ptr),
    .queue_full_i    (queue_full),
    .flush_i         (backend_flush_i),
    .ifu_valid_i     (ifu_o.valid),
    .redirect_i      (ifu_frontend_redirect_o),
    .train_valid_i   (train_q.valid),
    .commit_lane0_i  (backend_commit_bitmask_i[0]),
    .commit_branch_i (backend_commit_meta_i.is_branch)
);

`default_nettype wire

// File: dv/frontend_tb.sv
`include "frontend_config.svh"
`default_nettype none

module frontend_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ID_W = $clog2(`FTQ_SIZE);
    localparam int MAX_CYCLES = 2000;
    localparam logic [31:0] BOOT_PC = 32'h0000_1000;
    localparam logic [31:0] FLUSH_PC = 32'h2000_0000;
    // Branch block and its taken target
    localparam logic [31:0] PC_A = 32'h4000_0000;
    localparam logic [31:0] PC_B = 32'h4000_0800;

    logic clk;
    logic rst;
    logic [31:0] boot_pc_i;
    logic [31:0] flush_target_pc_i;
    logic backend_flush_i;
    logic [ID_W-1:0] backend_flush_ftq_id_i;
    logic backend_ftq_meta_update_valid_i;
    logic backend_ftq_meta_update_ftb_dirty_i;
    logic [31:0] backend_ftq_meta_update_jump_target_i;
    logic [31:0] backend_ftq_meta_update_fall_through_i;
    logic [ID_W-1:0] backend_ftq_update_meta_id_i;
    logic [`COMMIT_WIDTH-1:0] backend_commit_bitmask_i;
    logic [ID_W-1:0] backend_commit_ftq_id_i;
    ftq_types_pkg::backend_commit_meta_t backend_commit_meta_i;
    logic [ID_W-1:0] ex_query_addr_i;
    logic [31:0] ex_query_pc_o;
    ftq_types_pkg::ftq_ifu_t ifu_o;
    logic ifu_frontend_redirect_o;
    logic [ID_W-1:0] ifu_ftq_id_o;
    logic ifu_accept_i;

    // Scoreboard of accepted blocks by ftq id
    logic [31:0] sb [`FTQ_SIZE];
    // Ids accepted but not yet committed
    logic [ID_W-1:0] outq [$];
    logic [31:0] rng = 32'h8420;
    logic [31:0] expected_pc;
    logic [ID_W-1:0] expected_id;
    logic [ID_W-1:0] last_id;
    logic [31:0] last_pc;
    logic [ID_W-1:0] branch_id;
    logic branch_armed;
    logic pulse_seen;
    logic [31:0] held_pc;
    int ctr_model;
    int accepts;
    int errors;
    int cycles;
    int n0;

    frontend_top dut0 (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    // One clock of stimulus driven on the falling edge
    task automatic drive_cycle(input logic accept, input int ncommit,
                               input logic flush, input logic meta_upd);
        int n;
        @(negedge clk);
        rng = xorshift32(rng);
        n = (ncommit > outq.size()) ? outq.size() : ncommit;
        ifu_accept_i = accept & ~flush;
        backend_commit_bitmask_i = (n == 2) ? 2'b11 : (n == 1) ? 2'b01 : 2'b00;
        backend_commit_ftq_id_i = (outq.size() > 0) ? outq[0] : '0;
        backend_commit_meta_i = '0;
        if (n > 0 && branch_armed && outq[0] == branch_id) begin
            backend_commit_meta_i.is_branch = 1'b1;
            backend_commit_meta_i.is_conditional = 1'b1;
            backend_commit_meta_i.is_taken = 1'b1;
        end
        backend_flush_i = flush;
        backend_flush_ftq_id_i = last_id;
        backend_ftq_meta_update_valid_i = meta_upd;
        backend_ftq_update_meta_id_i = branch_id;
        if (outq.size() > 0) begin
            ex_query_addr_i = outq[rng % outq.size()];
        end
        #1;
        if (outq.size() > 0) begin
            check_value("ex_query", sb[ex_query_addr_i], ex_query_pc_o);
        end
        if (ifu_frontend_redirect_o) begin
            pulse_seen = 1'b1;
        end
        if (ifu_o.valid && ifu_accept_i && !ifu_frontend_redirect_o) begin
            check_value("fetch_pc", expected_pc, ifu_o.start_pc);
            check_value("fetch_id", 32'(expected_id), 32'(ifu_ftq_id_o));
            check_value("fetch_len", `FETCH_BYTES / 4, 32'(ifu_o.length));
            // Only the block corrected by P1 carries a taken prediction
            check_value("fetch_taken", 32'(expected_pc == PC_A && ctr_model >= 2),
                        32'(ifu_o.predicted_taken));
            check_value("fetch_cross", 32'(expected_pc % `FETCH_BYTES != 0),
                        32'(ifu_o.is_cross_cacheline));
            sb[ifu_ftq_id_o] = ifu_o.start_pc;
            outq.push_back(ifu_ftq_id_o);
            last_id = ifu_ftq_id_o;
            last_pc = ifu_o.start_pc;
            accepts++;
            expected_id = ID_W'(expected_id + 1);
            if (last_pc == PC_A && ctr_model >= 2) begin
                expected_pc = PC_B;
            end else begin
                expected_pc = last_pc + `FETCH_BYTES;
            end
        end
        repeat (n) void'(outq.pop_front());
        if (flush) begin
            expected_id = ID_W'(last_id + 1);
            expected_pc = flush_target_pc_i;
        end
    endtask

    task automatic accept_one();
        n0 = accepts;
        while (accepts == n0) begin
            drive_cycle(1'b1, 0, 1'b0, 1'b0);
        end
    endtask

    task automatic drain_commits(input int width);
        while (outq.size() > 0) begin
            drive_cycle(1'b0, width, 1'b0, 1'b0);
        end
    endtask

    initial begin
        rst = 1'b1;
        boot_pc_i = BOOT_PC;
        flush_target_pc_i = FLUSH_PC;
        backend_flush_i = 1'b0;
        backend_flush_ftq_id_i = '0;
        backend_ftq_meta_update_valid_i = 1'b0;
        backend_ftq_meta_update_ftb_dirty_i = 1'b0;
        backend_ftq_meta_update_jump_target_i = PC_B;
        backend_ftq_meta_update_fall_through_i = PC_A + `FETCH_BYTES;
        backend_ftq_update_meta_id_i = '0;
        backend_commit_bitmask_i = '0;
        backend_commit_ftq_id_i = '0;
        backend_commit_meta_i = '0;
        ex_query_addr_i = '0;
        ifu_accept_i = 1'b0;
        expected_pc = BOOT_PC;
        expected_id = '0;
        last_id = '0;
        last_pc = '0;
        branch_id = '0;
        branch_armed = 1'b0;
        pulse_seen = 1'b0;
        ctr_model = 0;
        accepts = 0;
        errors = 0;
        cycles = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        #1;
        check_value("reset_valid", 32'd0, 32'(ifu_o.valid));
        check_value("reset_redirect", 32'd0, 32'(ifu_frontend_redirect_o));

        // Sequential fetch with random accepts and commits
        repeat (150) begin
            rng = xorshift32(rng);
            drive_cycle(rng[0] | rng[1], int'(rng[4]) + int'(rng[5]), 1'b0, 1'b0);
        end

        // Back-pressure holds the head and keeps one slot free
        drain_commits(2);
        repeat (8) drive_cycle(1'b0, 0, 1'b0, 1'b0);
        held_pc = ifu_o.start_pc;
        repeat (10) begin
            drive_cycle(1'b0, 0, 1'b0, 1'b0);
            check_value("hold_valid", 32'd1, 32'(ifu_o.valid));
            check_value("hold_pc", held_pc, ifu_o.start_pc);
        end
        n0 = accepts;
        repeat (20) drive_cycle(1'b1, 0, 1'b0, 1'b0);
        check_value("full_count", `FTQ_SIZE - 1, accepts - n0);
        drain_commits(2);
        accept_one();

        // Flush to a new target
        flush_target_pc_i = FLUSH_PC;
        drive_cycle(1'b0, 0, 1'b1, 1'b0);
        accept_one();

        // Train A as taken to B and refetch it
        for (int r = 0; r < 3; r++) begin
            pulse_seen = 1'b0;
            flush_target_pc_i = PC_A;
            drive_cycle(1'b0, 0, 1'b1, 1'b0);
            do begin
                drive_cycle(1'b1, 0, 1'b0, 1'b0);
            end while (last_pc != PC_A);
            check_value("redirect_pulse", 32'(ctr_model >= 2), 32'(pulse_seen));
            branch_id = last_id;
            drive_cycle(1'b0, 0, 1'b0, 1'b1);
            branch_armed = 1'b1;
            drain_commits(1);
            branch_armed = 1'b0;
            // Conditional taken allocates at 2 and counts up to 3
            ctr_model = (ctr_model == 0) ? 2 : 3;
            repeat (3) drive_cycle(1'b0, 0, 1'b0, 1'b0);
            accept_one();
        end

        if (errors == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: source/bpu.sv
`include "frontend_config.svh"
`default_nettype none

module bpu (
    input wire                   clk,
    input wire                   rst,
    input wire                   flush_i,
    input wire [`ADDR_WIDTH-1:0] flush_target_pc_i,
    input wire [`ADDR_WIDTH-1:0] boot_pc_i,
    bpu_ftq_if.bpu               ftq
);

    localparam int OFF_W = $clog2(`FETCH_BYTES);
    localparam int IDX_W = $clog2(`FTB_ENTRIES);
    localparam int TAG_W = `ADDR_WIDTH - OFF_W - IDX_W;
    localparam int BLOCK_INSTS = `FETCH_BYTES / 4;

    // FTB storage
    logic [`FTB_ENTRIES-1:0] ftb_valid;
    logic [TAG_W-1:0]        ftb_tag    [`FTB_ENTRIES];
    logic [`ADDR_WIDTH-1:0]  ftb_target [`FTB_ENTRIES];
    logic [1:0]              ftb_ctr    [`FTB_ENTRIES];

    // Pipeline state
    logic [`ADDR_WIDTH-1:0] p0_pc;
    logic                   p1_valid;
    logic [`ADDR_WIDTH-1:0] p1_pc;

    logic [IDX_W-1:0] p1_idx;
    logic             p1_hit;
    logic [IDX_W-1:0] train_idx;
    logic [1:0]       train_ctr;
    logic             train_alloc;

    function automatic bpu_types_pkg::bpu_ftq_t make_block(
        input logic                   valid,
        input logic [`ADDR_WIDTH-1:0] pc,
        input logic                   taken
    );
        bpu_types_pkg::bpu_ftq_t blk;
        blk.valid = valid;
        blk.start_pc = pc;
        blk.length = bpu_types_pkg::fetch_len_t'(BLOCK_INSTS);
        blk.predicted_taken = taken;
        // Unaligned start runs into the next fetch line
        blk.is_cross_cacheline = |pc[OFF_W-1:0];
        return blk;
    endfunction

    // P0 always proposes the next sequential block
    assign ftq.p0 = make_block(~ftq.queue_full & ~rst, p0_pc, 1'b0);

    // P1 looks up the block P0 issued last cycle
    assign p1_idx = p1_pc[OFF_W +: IDX_W];
    assign p1_hit = ftb_valid[p1_idx] && ftb_tag[p1_idx] == p1_pc[`ADDR_WIDTH-1 -: TAG_W];

    // Disagree only on a strong-enough taken prediction off the sequential path
    assign ftq.redirect = p1_valid && p1_hit && ftb_ctr[p1_idx][1]
                          && ftb_target[p1_idx] != p1_pc + `ADDR_WIDTH'(`FETCH_BYTES);
    assign ftq.p1 = make_block(ftq.redirect, p1_pc, 1'b1);

    assign ftq.p1_meta.ftb_hit = p1_hit;
    assign ftq.p1_meta.provider_ctr_bits = p1_hit ? ftb_ctr[p1_idx] : 2'b00;

    always_ff @(posedge clk) begin
        if (rst) begin
            p0_pc <= boot_pc_i;
            p1_valid <= 1'b0;
        end else begin
            // Wrong-path proposal dies on redirect or flush
            p1_valid <= ftq.p0.valid & ~ftq.redirect & ~flush_i;
            if (flush_i) begin
                p0_pc <= flush_target_pc_i;
            end else if (ftq.redirect) begin
                p0_pc <= ftb_target[p1_idx];
            end else if (ftq.p0.valid) begin
                p0_pc <= p0_pc + `ADDR_WIDTH'(`FETCH_BYTES);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ftq.p0.valid) begin
            p1_pc <= p0_pc;
        end
    end

    // Training uses the counter from the stored P1 lookup
    assign train_idx = ftq.train.start_pc[OFF_W +: IDX_W];

    always_comb begin
        train_ctr = ftq.train.provider_ctr_bits;
        train_alloc = 1'b0;
        if (ftq.train.is_taken) begin
            if (!ftq.train.ftb_hit || ftq.train.ftb_dirty) begin
                // New or stale line is allocated unless the target equals fall-through
                train_alloc = ftq.train.jump_target_address
                              != ftq.train.fall_through_address;
                train_ctr = ftq.train.is_conditional ? 2'd2 : 2'd3;
            end else if (train_ctr != 2'd3) begin
                train_ctr = train_ctr + 2'd1;
            end
        end else if (train_ctr != 2'd0) begin
            train_ctr = train_ctr - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ftb_valid <= '0;
        end else if (ftq.train.valid && train_alloc) begin
            ftb_valid[train_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ftq.train.valid) begin
            if (train_alloc) begin
                ftb_tag[train_idx] <= ftq.train.start_pc[`ADDR_WIDTH-1 -: TAG_W];
                ftb_target[train_idx] <= ftq.train.jump_target_address;
            end
            // Counter of a missed line belongs to some other block
            if (train_alloc || ftq.train.ftb_hit) begin
                ftb_ctr[train_idx] <= train_ctr;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/bpu_ftq_if.sv
`default_nettype none

interface bpu_ftq_if;

    // Prediction path
    bpu_types_pkg::bpu_ftq_t      p0;
    bpu_types_pkg::bpu_ftq_t      p1;
    bpu_types_pkg::bpu_ftq_meta_t p1_meta;
    logic                         redirect;

    // Back-pressure and training path
    logic                         queue_full;
    bpu_types_pkg::ftq_bpu_meta_t train;

    modport bpu (
        output p0, p1, p1_meta, redirect,
        input  queue_full, train
    );

    modport ftq (
        input  p0, p1, p1_meta, redirect,
        output queue_full, train
    );

endinterface

`default_nettype wire

// File: source/bpu_types_pkg.sv
`include "frontend_config.svh"
`default_nettype none

package bpu_types_pkg;

    // Instruction count of a block, 4-byte instructions
    typedef logic [$clog2(`FETCH_BYTES / 4):0] fetch_len_t;

    // Block proposed by P0 or corrected by P1
    typedef struct packed {
        logic                   valid;
        logic [`ADDR_WIDTH-1:0] start_pc;
        fetch_len_t             length;
        logic                   predicted_taken;
        logic                   is_cross_cacheline;
    } bpu_ftq_t;

    // FTB lookup result kept with each queue entry
    typedef struct packed {
        logic       ftb_hit;
        logic [1:0] provider_ctr_bits;
    } bpu_ftq_meta_t;

    // Training record sent back when a branch commits
    typedef struct packed {
        logic                   valid;
        logic [`ADDR_WIDTH-1:0] start_pc;
        logic                   ftb_hit;
        logic                   ftb_dirty;
        logic                   is_conditional;
        logic                   is_taken;
        logic                   predicted_taken;
        logic [1:0]             provider_ctr_bits;
        logic [`ADDR_WIDTH-1:0] jump_target_address;
        logic [`ADDR_WIDTH-1:0] fall_through_address;
    } ftq_bpu_meta_t;

endpackage

`default_nettype wire

// File: source/frontend_config.svh
`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

// Fetch target queue entries, one slot is kept free to tell full from empty
`define FTQ_SIZE 8

`define ADDR_WIDTH 32

// Blocks the backend may retire in one cycle
`define COMMIT_WIDTH 2

// Lines in the fetch target buffer
`define FTB_ENTRIES 16

// Bytes covered by one fetch block
`define FETCH_BYTES 16

`endif

// File: source/frontend_top.sv
`include "frontend_config.svh"
`default_nettype none

module frontend_top (
    input wire                               clk,
    input wire                               rst,
    input wire [`ADDR_WIDTH-1:0]             boot_pc_i,
    input wire [`ADDR_WIDTH-1:0]             flush_target_pc_i,

    // Backend
    input wire                               backend_flush_i,
    input wire [$clog2(`FTQ_SIZE)-1:0]       backend_flush_ftq_id_i,
    input wire                               backend_ftq_meta_update_valid_i,
    input wire                               backend_ftq_meta_update_ftb_dirty_i,
    input wire [`ADDR_WIDTH-1:0]             backend_ftq_meta_update_jump_target_i,
    input wire [`ADDR_WIDTH-1:0]             backend_ftq_meta_update_fall_through_i,
    input wire [$clog2(`FTQ_SIZE)-1:0]       backend_ftq_update_meta_id_i,
    input wire [`COMMIT_WIDTH-1:0]           backend_commit_bitmask_i,
    input wire [$clog2(`FTQ_SIZE)-1:0]       backend_commit_ftq_id_i,
    input wire ftq_types_pkg::backend_commit_meta_t backend_commit_meta_i,

    // EX query
    input wire [$clog2(`FTQ_SIZE)-1:0]       ex_query_addr_i,
    output logic [`ADDR_WIDTH-1:0]           ex_query_pc_o,

    // IFU
    output ftq_types_pkg::ftq_ifu_t          ifu_o,
    output logic                             ifu_frontend_redirect_o,
    output logic [$clog2(`FTQ_SIZE)-1:0]     ifu_ftq_id_o,
    input wire                               ifu_accept_i
);

    bpu_ftq_if bpu_ftq ();

    // Backend flush also restarts P0
    bpu u_bpu (
        .clk               (clk),
        .rst               (rst),
        .flush_i           (backend_flush_i),
        .flush_target_pc_i (flush_target_pc_i),
        .boot_pc_i         (boot_pc_i),
        .ftq               (bpu_ftq.bpu)
    );

    ftq u_ftq (
        .clk                                    (clk),
        .rst                                    (rst),
        .bpu                                    (bpu_ftq.ftq),
        .backend_flush_i                        (backend_flush_i),
        .backend_flush_ftq_id_i                 (backend_flush_ftq_id_i),
        .backend_ftq_meta_update_valid_i        (backend_ftq_meta_update_valid_i),
        .backend_ftq_meta_update_ftb_dirty_i    (backend_ftq_meta_update_ftb_dirty_i),
        .backend_ftq_meta_update_jump_target_i  (backend_ftq_meta_update_jump_target_i),
        .backend_ftq_meta_update_fall_through_i (backend_ftq_meta_update_fall_through_i),
        .backend_ftq_update_meta_id_i           (backend_ftq_update_meta_id_i),
        .backend_commit_bitmask_i               (backend_commit_bitmask_i),
        .backend_commit_ftq_id_i                (backend_commit_ftq_id_i),
        .backend_commit_meta_i                  (backend_commit_meta_i),
        .ex_query_addr_i                        (ex_query_addr_i),
        .ex_query_pc_o                          (ex_query_pc_o),
        .ifu_o                                  (ifu_o),
        .ifu_frontend_redirect_o                (ifu_frontend_redirect_o),
        .ifu_ftq_id_o                           (ifu_ftq_id_o),
        .ifu_accept_i                           (ifu_accept_i)
    );

endmodule

`default_nettype wire

// File: source/ftq.sv
`include "frontend_config.svh"
`default_nettype none

module ftq (
    input wire clk,
    input wire rst,
    bpu_ftq_if.ftq bpu,

    // Backend
    input wire                               backend_flush_i,
    input wire [$clog2(`FTQ_SIZE)-1:0]       backend_flush_ftq_id_i,
    input wire                               backend_ftq_meta_update_valid_i,
    input wire                               backend_ftq_meta_update_ftb_dirty_i,
    input wire [`ADDR_WIDTH-1:0]             backend_ftq_meta_update_jump_target_i,
    input wire [`ADDR_WIDTH-1:0]             backend_ftq_meta_update_fall_through_i,
    input wire [$clog2(`FTQ_SIZE)-1:0]       backend_ftq_update_meta_id_i,
    input wire [`COMMIT_WIDTH-1:0]           backend_commit_bitmask_i,
    input wire [$clog2(`FTQ_SIZE)-1:0]       backend_commit_ftq_id_i,
    input wire ftq_types_pkg::backend_commit_meta_t backend_commit_meta_i,

    // EX query
    input wire [$clog2(`FTQ_SIZE)-1:0]       ex_query_addr_i,
    output logic [`ADDR_WIDTH-1:0]           ex_query_pc_o,

    // IFU
    output ftq_types_pkg::ftq_ifu_t          ifu_o,
    output logic                             ifu_frontend_redirect_o,
    output logic [$clog2(`FTQ_SIZE)-1:0]     ifu_ftq_id_o,
    input wire                               ifu_accept_i
);

    localparam int PTR_W = $clog2(`FTQ_SIZE);
    localparam int CNT_W = $clog2(`COMMIT_WIDTH) + 1;

    ftq_types_pkg::ftq_block_t [`FTQ_SIZE-1:0] queue_q;
    ftq_types_pkg::ftq_block_t [`FTQ_SIZE-1:0] queue_d;
    ftq_types_pkg::ftq_meta_entry_t meta_q [`FTQ_SIZE];
    bpu_types_pkg::ftq_bpu_meta_t train_q;

    logic [PTR_W-1:0] bpu_ptr;
    logic [PTR_W-1:0] ifu_ptr;
    logic [PTR_W-1:0] comm_ptr;
    logic [PTR_W-1:0] bpu_ptr_m1;
    logic [CNT_W-1:0] commit_num;

    logic queue_full;
    logic override;
    logic p0_wr;
    logic p0_wr_q;
    logic ifu_take;
    logic ifu_take_q;

    always_comb begin
        commit_num = '0;
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            commit_num = commit_num + CNT_W'(backend_commit_bitmask_i[i]);
        end
    end

    assign bpu_ptr_m1 = PTR_W'(bpu_ptr - 1'b1);
    assign queue_full = PTR_W'(bpu_ptr + 1'b1) == comm_ptr;
    assign bpu.queue_full = queue_full;

    // P1 may only rewrite the slot P0 filled last cycle
    assign override = bpu.p1.valid & bpu.redirect & p0_wr_q & ~backend_flush_i;
    assign p0_wr = bpu.p0.valid & ~queue_full & ~override;
    assign ifu_take = queue_q[ifu_ptr].valid & ifu_accept_i;

    // IFU holds the overridden block, now or from last cycle
    assign ifu_frontend_redirect_o = override
        & ((ifu_take & ifu_ptr == bpu_ptr_m1) | (ifu_take_q & ifu_ptr == bpu_ptr));

    always_ff @(posedge clk) begin
        if (rst) begin
            bpu_ptr <= '0;
            ifu_ptr <= '0;
            comm_ptr <= '0;
            p0_wr_q <= 1'b0;
            ifu_take_q <= 1'b0;
        end else begin
            comm_ptr <= comm_ptr + PTR_W'(commit_num);
            p0_wr_q <= p0_wr & ~backend_flush_i;
            ifu_take_q <= ifu_take & ~ifu_frontend_redirect_o;
            if (backend_flush_i) begin
                bpu_ptr <= PTR_W'(backend_flush_ftq_id_i + 1'b1);
                ifu_ptr <= PTR_W'(backend_flush_ftq_id_i + 1'b1);
            end else begin
                if (p0_wr) begin
                    bpu_ptr <= PTR_W'(bpu_ptr + 1'b1);
                end
                // Refetch the corrected block
                if (ifu_frontend_redirect_o) begin
                    ifu_ptr <= bpu_ptr_m1;
                end else if (ifu_take) begin
                    ifu_ptr <= PTR_W'(ifu_ptr + 1'b1);
                end
            end
        end
    end

    always_comb begin
        queue_d = queue_q;
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            if (i < commit_num) begin
                queue_d[PTR_W'(comm_ptr + i)] = '0;
            end
        end
        if (p0_wr) begin
            queue_d[bpu_ptr] = bpu.p0;
        end
        if (override) begin
            queue_d[bpu_ptr_m1] = bpu.p1;
        end
        // Drop everything younger than the flushed block
        if (backend_flush_i) begin
            for (int i = 0; i < `FTQ_SIZE; i++) begin
                if (PTR_W'(i - comm_ptr) > PTR_W'(backend_flush_ftq_id_i - comm_ptr)) begin
                    queue_d[i] = '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            queue_q <= '0;
        end else begin
            queue_q <= queue_d;
        end
    end

    // Metadata store
    always_ff @(posedge clk) begin
        // P1 lookup of the block written last cycle
        if (p0_wr_q) begin
            meta_q[bpu_ptr_m1] <= '{
                ftb_hit: bpu.p1_meta.ftb_hit,
                provider_ctr_bits: bpu.p1_meta.provider_ctr_bits,
                default: '0
            };
        end
        if (backend_ftq_meta_update_valid_i) begin
            meta_q[backend_ftq_update_meta_id_i].ftb_dirty <=
                backend_ftq_meta_update_ftb_dirty_i;
            meta_q[backend_ftq_update_meta_id_i].jump_target_address <=
                backend_ftq_meta_update_jump_target_i;
            meta_q[backend_ftq_update_meta_id_i].fall_through_address <=
                backend_ftq_meta_update_fall_through_i;
        end
    end

    // Training record, lane 0 only
    always_ff @(posedge clk) begin
        if (rst) begin
            train_q <= '0;
        end else begin
            train_q <= '0;
            if (backend_commit_bitmask_i[0] & backend_commit_meta_i.is_branch) begin
                train_q.valid <= 1'b1;
                train_q.start_pc <= queue_q[backend_commit_ftq_id_i].start_pc;
                train_q.ftb_hit <= meta_q[backend_commit_ftq_id_i].ftb_hit;
                train_q.ftb_dirty <= meta_q[backend_commit_ftq_id_i].ftb_dirty;
                train_q.is_conditional <= backend_commit_meta_i.is_conditional;
                train_q.is_taken <= backend_commit_meta_i.is_taken;
                train_q.predicted_taken <= backend_commit_meta_i.predicted_taken;
                train_q.provider_ctr_bits <= meta_q[backend_commit_ftq_id_i].provider_ctr_bits;
                train_q.jump_target_address <=
                    meta_q[backend_commit_ftq_id_i].jump_target_address;
                train_q.fall_through_address <=
                    meta_q[backend_commit_ftq_id_i].fall_through_address;
            end
        end
    end

    assign bpu.train = train_q;

    // Head block to the IFU
    assign ifu_o.valid = queue_q[ifu_ptr].valid;
    assign ifu_o.start_pc = queue_q[ifu_ptr].start_pc;
    assign ifu_o.length = queue_q[ifu_ptr].length;
    assign ifu_o.predicted_taken = queue_q[ifu_ptr].predicted_taken;
    assign ifu_o.is_cross_cacheline = queue_q[ifu_ptr].is_cross_cacheline;
    assign ifu_ftq_id_o = ifu_ptr;

    assign ex_query_pc_o = queue_q[ex_query_addr_i].start_pc;

endmodule

`default_nettype wire

// File: source/ftq_types_pkg.sv
`include "frontend_config.svh"
`default_nettype none

package ftq_types_pkg;

    // Head block offered to the IFU
    typedef struct packed {
        logic                     valid;
        logic [`ADDR_WIDTH-1:0]   start_pc;
        bpu_types_pkg::fetch_len_t length;
        logic                     predicted_taken;
        logic                     is_cross_cacheline;
    } ftq_ifu_t;

    // Per-lane branch info from the backend at commit
    typedef struct packed {
        logic is_branch;
        logic is_conditional;
        logic is_taken;
        logic predicted_taken;
    } backend_commit_meta_t;

    // Queue slot
    typedef struct packed {
        logic                     valid;
        logic [`ADDR_WIDTH-1:0]   start_pc;
        bpu_types_pkg::fetch_len_t length;
        logic                     predicted_taken;
        logic                     is_cross_cacheline;
    } ftq_block_t;

    // Metadata slot, filled by P1 and later by the backend
    typedef struct packed {
        logic                   ftb_hit;
        logic                   ftb_dirty;
        logic [1:0]             provider_ctr_bits;
        logic [`ADDR_WIDTH-1:0] jump_target_address;
        logic [`ADDR_WIDTH-1:0] fall_through_address;
    } ftq_meta_entry_t;

endpackage

`default_nettype wire
